// ==== bench/sa_ctrl_props.sv ====
`timescale 1ns/100ps

module sa_ctrl_props (
    input logic              clk,
    input logic              reset_n,
    input sa_pkg::wb_req_t   wb_req,
    input logic              wb_ack,
    input sa_pkg::ub_ctrl_t  ub_ctrl,
    input sa_pkg::acc_ctrl_t acc_ctrl,
    input sa_pkg::mmu_ctrl_t mmu_ctrl
);

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!reset_n)
        wb_req.stb |-> wb_req.cyc)
        else $error("Wishbone stb high without cyc");

    // Request frozen until the slave acks
    a_req_stable: assert property (@(posedge clk) disable iff (!reset_n)
        (wb_req.stb && !wb_ack) |=> $stable(wb_req))
        else $error("Wishbone request changed before ack");

    a_ub_one_port: assert property (@(posedge clk)
        !(ub_ctrl.rd_en && ub_ctrl.wr_en))
        else $error("UB read and write in the same cycle");

    // From the second reset edge on, registers hold their reset values
    a_quiet_in_reset: assert property (@(posedge clk)
        (!reset_n && $past(!reset_n)) |->
            (!wb_req.cyc && !wb_req.stb && !ub_ctrl.rd_en && !ub_ctrl.wr_en &&
             !acc_ctrl.rd_en && !acc_ctrl.wr_en && mmu_ctrl == '0))
        else $error("Enable high during reset");

endmodule

bind sa_ctrl_top sa_ctrl_props props0 (
    .clk      (clk),
    .reset_n  (reset_n),
    .wb_req   (wb_req),
    .wb_ack   (wb_ack),
    .ub_ctrl  (ub_ctrl),
    .acc_ctrl (acc_ctrl),
    .mmu_ctrl (mmu_ctrl)
);

// ==== bench/tb_sa_ctrl.sv ====
`timescale 1ns/100ps

module tb_sa_ctrl;
    import sa_pkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int TIMEOUT     = 200;   // Cycles allowed per wait

    typedef enum {W_IDLE, W_ACTIVE, W_UB_WRITE} wait_t;

    logic      clk;
    logic      reset_n;
    inst_t     inst;
    logic      inst_valid;
    logic      inst_ready;
    wb_req_t   wb_req;
    data_t     wb_rdata;
    logic      wb_ack;
    data_t     ub_rdata;
    data_t     acc_rdata;
    ub_ctrl_t  ub_ctrl;
    acc_ctrl_t acc_ctrl;
    mmu_ctrl_t mmu_ctrl;
    data_t     ub_wdata;
    logic      idle;

    int        seed = 60;
    int        ack_wait;
    logic      ack_hold;       // Slave stalls while set
    logic      slave_busy;
    wb_req_t   wb_log [$];     // Request seen at each ack
    data_t     rd_log [$];

    sa_ctrl_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////
    // Wishbone slave
    //////////////////////////////

    initial begin
        forever begin
            @(posedge clk);
            #10;
            if (wb_ack) begin
                wb_ack     = 1'b0;    // Single cycle ack
                wb_rdata   = '0;      // Read data only valid with ack
                slave_busy = 1'b0;
            end else if (wb_req.cyc && wb_req.stb && !ack_hold) begin
                if (!slave_busy) begin
                    slave_busy = 1'b1;
                    ack_wait   = {$random(seed)} % 6;
                end
                if (ack_wait == 0) begin
                    wb_rdata = rand_word();
                    wb_ack   = 1'b1;
                    wb_log.push_back(wb_req);
                    rd_log.push_back(wb_rdata);
                end else begin
                    ack_wait--;
                end
            end
        end
    end

    //////////////////////////////
    // Helpers and checks
    //////////////////////////////

    function automatic data_t rand_word();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    function automatic inst_t make_inst(input logic [3:0] op, input offmem_addr_t a,
                                        input offmem_addr_t b);
        return {op, a, b};
    endfunction

    function automatic logic cond_met(input wait_t what);
        case (what)
            W_IDLE:   return idle;
            W_ACTIVE: return ub_ctrl != '0 || acc_ctrl != '0 || mmu_ctrl != '0 || wb_req.cyc;
            default:  return ub_ctrl.wr_en;
        endcase
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_ub(input string name, input ub_ctrl_t got, input ub_ctrl_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_acc(input string name, input acc_ctrl_t got, input acc_ctrl_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_mmu(input string name, input mmu_ctrl_t got, input mmu_ctrl_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_wb(input string name, input wb_req_t got, input wb_req_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_ctrl(input ub_ctrl_t eu, input acc_ctrl_t ea, input mmu_ctrl_t em);
        check_ub("ub_ctrl", ub_ctrl, eu);
        check_acc("acc_ctrl", acc_ctrl, ea);
        check_mmu("mmu_ctrl", mmu_ctrl, em);
    endtask

    task automatic check_log(input int n);
        if (wb_log.size() != n) begin
            stop_with_error($sformatf("Expected %0d Wishbone transfers but saw %0d",
                                      n, wb_log.size()));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    // Samples at the falling edge, mid cycle
    task automatic wait_for(input wait_t what);
        int t;
        t = 0;
        @(negedge clk);
        while (!cond_met(what)) begin
            t++;
            if (t > TIMEOUT) begin
                stop_with_error($sformatf("Timed out waiting for %s", what.name()));
            end
            @(negedge clk);
        end
    endtask

    task automatic push_inst(input inst_t i);
        int t;
        t = 0;
        next_cycle();
        inst       = i;
        inst_valid = 1'b1;
        while (!inst_ready) begin
            t++;
            if (t > TIMEOUT) begin
                stop_with_error("Instruction queue never accepted the instruction");
            end
            next_cycle();
        end
        next_cycle();           // Taken on this edge
        inst_valid = 1'b0;
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic noop_after_reset();
        inst_t i;
        int    t;
        int    k;
        check_bit("idle", idle, 1'b1);
        check_bit("inst_ready", inst_ready, 1'b1);
        check_ctrl('0, '0, '0);
        check_wb("wb_req", wb_req, '0);
        for (k = 0; k < 2; k++) begin
            i = make_inst(k == 0 ? 4'd0 : 4'd1, 32'h0000_0011, 32'h0000_0022);
            push_inst(i);
            t = 0;
            @(negedge clk);
            check_bit("idle", idle, 1'b0);
            while (!idle) begin
                check_ctrl('0, '0, '0);
                check_wb("wb_req", wb_req, '0);
                t++;
                if (t > TIMEOUT) begin
                    stop_with_error("No-op instruction never finished");
                end
                @(negedge clk);
            end
        end
    endtask

    task automatic fifo_feed();
        inst_t     i;
        ub_ctrl_t  eu;
        mmu_ctrl_t em;
        i = make_inst(4'd5, 32'h0000_0003, 32'h0000_01c4);
        push_inst(i);
        wait_for(W_ACTIVE);
        eu = '0;
        eu.rd_en = 1'b1;
        eu.rd_addr = i.addrb[UB_ADDR_W-1:0];
        em = '0;
        em.data_fifo_en = 1'b1;
        check_ctrl(eu, '0, em);
        wait_for(W_IDLE);
    endtask

    task automatic mat_mul_steps(input logic acc_mode);
        inst_t     i;
        ub_ctrl_t  eu;
        acc_ctrl_t ea;
        mmu_ctrl_t em;
        i = make_inst(acc_mode ? 4'd8 : 4'd7, 32'h0000_0a5b, 32'h0000_0337);
        push_inst(i);
        wait_for(W_ACTIVE);
        eu = '0;
        eu.rd_en = 1'b1;
        eu.rd_addr = i.addrb[UB_ADDR_W-1:0];
        em = '0;
        em.acc_en = acc_mode;
        check_ctrl(eu, '0, em);
        @(negedge clk);
        ea = '0;
        ea.wr_en = 1'b1;
        ea.wr_addr = i.addra[ACC_ADDR_W-1:0];
        em.mm_en = 1'b1;
        em.data_fifo_en = 1'b1;
        check_ctrl('0, ea, em);
        wait_for(W_IDLE);
    endtask

    task automatic acc_writeback();
        inst_t     i;
        ub_ctrl_t  eu;
        acc_ctrl_t ea;
        data_t     val;
        i = make_inst(4'd9, 32'h0000_0077, 32'h0000_00e9);
        push_inst(i);
        wait_for(W_ACTIVE);
        ea = '0;
        ea.rd_en = 1'b1;
        ea.rd_addr = i.addrb[ACC_ADDR_W-1:0];
        check_ctrl('0, ea, '0);
        next_cycle();
        val = rand_word();
        acc_rdata = val;        // ACC answers the cycle after rd_en
        @(negedge clk);
        eu = '0;
        eu.wr_en = 1'b1;
        eu.wr_addr = i.addra[UB_ADDR_W-1:0];
        check_ctrl(eu, '0, '0);
        check_data("ub_wdata", ub_wdata, val);
        wait_for(W_IDLE);
    endtask

    task automatic offmem_load();
        inst_t    i;
        ub_ctrl_t eu;
        wb_req_t  ew;
        i = make_inst(4'd3, 32'h0000_0042, 32'h1234_5678);
        push_inst(i);
        wait_for(W_ACTIVE);
        ew = '0;
        ew.cyc = 1'b1;
        ew.stb = 1'b1;
        ew.adr = i.addrb;
        check_wb("wb_req", wb_req, ew);
        check_ctrl('0, '0, '0);
        wait_for(W_UB_WRITE);
        eu = '0;
        eu.wr_en = 1'b1;
        eu.wr_addr = i.addra[UB_ADDR_W-1:0];
        check_ctrl(eu, '0, '0);
        check_log(1);
        check_data("ub_wdata", ub_wdata, rd_log.pop_front());
        check_wb("wb_req at ack", wb_log.pop_front(), ew);
        wait_for(W_IDLE);
    endtask

    task automatic offmem_store();
        inst_t    i;
        ub_ctrl_t eu;
        wb_req_t  ew;
        data_t    val;
        int       k;
        ack_hold = 1'b1;
        i = make_inst(4'd10, 32'h8000_1f00, 32'h0000_0051);
        push_inst(i);
        wait_for(W_ACTIVE);
        eu = '0;
        eu.rd_en = 1'b1;
        eu.rd_addr = i.addrb[UB_ADDR_W-1:0];
        check_ctrl(eu, '0, '0);
        next_cycle();
        val = rand_word();
        ub_rdata = val;
        @(negedge clk);
        check_ctrl('0, '0, '0);
        ew = '0;
        ew.cyc = 1'b1;
        ew.stb = 1'b1;
        ew.we = 1'b1;
        ew.adr = i.addra;
        ew.wdata = val;
        for (k = 0; k < 3; k++) begin
            next_cycle();
            ub_rdata = rand_word();     // Master keeps its own copy
            @(negedge clk);
            check_wb("wb_req", wb_req, ew);
        end
        ack_hold = 1'b0;
        wait_for(W_IDLE);
        check_log(1);
        check_wb("wb_req at ack", wb_log.pop_front(), ew);
        rd_log.delete();
    endtask

    task automatic queue_backpressure();
        inst_t   i;
        wb_req_t ew;
        wb_req_t exp_q [$];
        data_t   store_data;
        int      k;
        ack_hold = 1'b1;
        next_cycle();
        store_data = rand_word();
        ub_rdata = store_data;
        // Stores and loads alternate, the first store blocks the bus
        for (k = 0; k <= QUEUE_DEPTH; k++) begin
            i = make_inst(k % 2 == 0 ? 4'd10 : 4'd3, 32'h9000_0000 + 32'(k),
                          32'h0000_0a00 + 32'(k));
            push_inst(i);
            ew = '0;
            ew.cyc = 1'b1;
            ew.stb = 1'b1;
            ew.we = (k % 2 == 0);
            ew.adr = ew.we ? i.addra : i.addrb;
            ew.wdata = ew.we ? store_data : '0;
            exp_q.push_back(ew);
        end
        check_bit("inst_ready", inst_ready, 1'b0);
        @(negedge clk);
        ack_hold = 1'b0;
        wait_for(W_IDLE);
        check_log(QUEUE_DEPTH + 1);
        for (k = 0; k <= QUEUE_DEPTH; k++) begin
            check_wb($sformatf("wb_req %0d", k), wb_log.pop_front(), exp_q.pop_front());
        end
        check_bit("inst_ready", inst_ready, 1'b1);
    endtask

    initial begin
        reset_n    = 1'b0;
        inst       = '0;
        inst_valid = 1'b0;
        wb_rdata   = '0;
        wb_ack     = 1'b0;
        ub_rdata   = '0;
        acc_rdata  = '0;
        ack_hold   = 1'b0;
        slave_busy = 1'b0;
        ack_wait   = 0;
        repeat (2) @(posedge clk);
        #10;
        reset_n = 1'b1;
        @(negedge clk);
        noop_after_reset();
        fifo_feed();
        mat_mul_steps(1'b0);
        mat_mul_steps(1'b1);
        acc_writeback();
        offmem_load();
        offmem_store();
        queue_backpressure();
        $display("sim passed");
        $finish;
    end

endmodule

// ==== files.f ====
hdl/sa_pkg.sv
hdl/inst_queue.sv
hdl/cu_sequencer.sv
hdl/buffer_port_gen.sv
hdl/offmem_master.sv
hdl/sa_ctrl_top.sv
bench/sa_ctrl_props.sv
bench/tb_sa_ctrl.sv

// ==== hdl/buffer_port_gen.sv ====
`timescale 1ns/100ps

module buffer_port_gen (
    input  sa_pkg::seq_state_t state,
    input  sa_pkg::inst_t      cur_inst,
    input  sa_pkg::data_t      acc_rdata,
    input  sa_pkg::data_t      rdata_q,
    output sa_pkg::ub_ctrl_t   ub_ctrl,
    output sa_pkg::acc_ctrl_t  acc_ctrl,
    output sa_pkg::mmu_ctrl_t  mmu_ctrl,
    output sa_pkg::data_t      ub_wdata
);
    import sa_pkg::*;

    ub_addr_t  ub_dst;
    ub_addr_t  ub_src;
    acc_addr_t acc_dst;
    acc_addr_t acc_src;

    // Buffers only see the low address bits
    assign ub_dst  = cur_inst.addra[UB_ADDR_W-1:0];
    assign ub_src  = cur_inst.addrb[UB_ADDR_W-1:0];
    assign acc_dst = cur_inst.addra[ACC_ADDR_W-1:0];
    assign acc_src = cur_inst.addrb[ACC_ADDR_W-1:0];

    always_comb begin
        ub_ctrl  = '0;
        acc_ctrl = '0;
        mmu_ctrl = '0;
        ub_wdata = '0;

        case (state)
            ST_STEP0: begin
                case (cur_inst.opcode)
                    OP_UB_TO_DATA_FIFO: begin
                        ub_ctrl.rd_en         = 1'b1;
                        ub_ctrl.rd_addr       = ub_src;
                        mmu_ctrl.data_fifo_en = 1'b1;
                    end
                    OP_MAT_MUL,
                    OP_MAT_MUL_ACC: begin
                        ub_ctrl.rd_en   = 1'b1;
                        ub_ctrl.rd_addr = ub_src;
                        mmu_ctrl.acc_en = (cur_inst.opcode == OP_MAT_MUL_ACC);
                    end
                    OP_ACC_TO_UB: begin
                        acc_ctrl.rd_en   = 1'b1;
                        acc_ctrl.rd_addr = acc_src;
                    end
                    OP_UB_TO_OFFMEM: begin
                        ub_ctrl.rd_en   = 1'b1;    // Store data for the bus
                        ub_ctrl.rd_addr = ub_src;
                    end
                    default: ;
                endcase
            end

            ST_STEP1: begin
                case (cur_inst.opcode)
                    OP_MAT_MUL,
                    OP_MAT_MUL_ACC: begin
                        acc_ctrl.wr_en        = 1'b1;
                        acc_ctrl.wr_addr      = acc_dst;
                        mmu_ctrl.mm_en        = 1'b1;
                        mmu_ctrl.data_fifo_en = 1'b1;
                        mmu_ctrl.acc_en       = (cur_inst.opcode == OP_MAT_MUL_ACC);
                    end
                    OP_ACC_TO_UB: begin
                        ub_ctrl.wr_en   = 1'b1;
                        ub_ctrl.wr_addr = ub_dst;
                        ub_wdata        = acc_rdata;  // Read data from STEP0
                    end
                    default: ;
                endcase
            end

            ST_WRITEBACK: begin
                if (cur_inst.opcode == OP_OFFMEM_TO_UB) begin
                    ub_ctrl.wr_en   = 1'b1;
                    ub_ctrl.wr_addr = ub_dst;
                    ub_wdata        = rdata_q;
                end
            end

            default: ;
        endcase
    end

endmodule

// ==== hdl/cu_sequencer.sv ====
`timescale 1ns/100ps

module cu_sequencer (
    input  logic               clk,
    input  logic               reset_n,
    input  sa_pkg::inst_t      head,
    input  logic               empty,
    output logic               pop,
    input  logic               done,
    output sa_pkg::seq_state_t state,
    output sa_pkg::inst_t      cur_inst,
    output logic               idle
);
    import sa_pkg::*;

    seq_state_t state_d;
    logic       fetch;
    logic       has_step1;    // Opcode needs a second fixed step
    logic       is_load;
    logic       is_store;

    assign fetch = (state == ST_FETCH) && !empty;
    assign pop   = fetch;
    assign idle  = (state == ST_FETCH) && empty;

    //////////////////////////////
    // Opcode classes
    //////////////////////////////

    assign is_load  = (cur_inst.opcode == OP_OFFMEM_TO_UB);
    assign is_store = (cur_inst.opcode == OP_UB_TO_OFFMEM);

    always_comb begin
        case (cur_inst.opcode)
            OP_MAT_MUL,
            OP_MAT_MUL_ACC,
            OP_ACC_TO_UB,
            OP_UB_TO_OFFMEM: has_step1 = 1'b1;
            default:         has_step1 = 1'b0;
        endcase
    end

    //////////////////////////////
    // Next state
    //////////////////////////////

    always_comb begin
        state_d = state;
        case (state)
            ST_FETCH: begin
                if (fetch) begin
                    state_d = ST_STEP0;
                end
            end
            ST_STEP0: begin
                if (is_load) begin
                    state_d = ST_BUS;       // Bus cycle starts from here
                end else if (has_step1) begin
                    state_d = ST_STEP1;
                end else begin
                    state_d = ST_FETCH;     // Single step, or no-op
                end
            end
            ST_STEP1: begin
                if (is_store) begin
                    state_d = ST_BUS;
                end else begin
                    state_d = ST_FETCH;
                end
            end
            ST_BUS: begin
                // Held here until the master reports the ack
                if (done) begin
                    state_d = is_load ? ST_WRITEBACK : ST_FETCH;
                end
            end
            ST_WRITEBACK: begin
                state_d = ST_FETCH;
            end
            default: begin
                state_d = ST_FETCH;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= ST_FETCH;
        end else begin
            state <= state_d;
        end
    end

    // Current instruction, held until the next fetch
    always_ff @(posedge clk) begin
        if (fetch) begin
            cur_inst <= head;
        end
    end

endmodule

// ==== hdl/inst_queue.sv ====
`timescale 1ns/100ps

module inst_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic          clk,
    input  logic          reset_n,
    input  sa_pkg::inst_t push_data,
    input  logic          push_valid,
    output logic          push_ready,
    input  logic          pop,
    output sa_pkg::inst_t head,
    output logic          empty
);
    import sa_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;   // Holds 0 .. QUEUE_DEPTH

    inst_t            mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign push_ready = (count != CNT_W'(QUEUE_DEPTH));
    assign empty      = (count == '0);
    assign head       = mem[rd_ptr];    // Oldest entry

    assign do_push = push_valid && push_ready;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

endmodule

// ==== hdl/offmem_master.sv ====
`timescale 1ns/100ps

module offmem_master (
    input  logic               clk,
    input  logic               reset_n,
    input  sa_pkg::seq_state_t state,
    input  sa_pkg::inst_t      cur_inst,
    input  sa_pkg::data_t      ub_rdata,
    output sa_pkg::wb_req_t    wb_req,
    input  sa_pkg::data_t      wb_rdata,
    input  logic               wb_ack,
    output sa_pkg::data_t      rdata_q,
    output logic               done
);
    import sa_pkg::*;

    wb_req_t req_q;
    logic    start_load;
    logic    start_store;
    logic    ack_hit;

    // Load starts one step earlier, store waits for the UB read data
    assign start_load  = (state == ST_STEP0) && (cur_inst.opcode == OP_OFFMEM_TO_UB);
    assign start_store = (state == ST_STEP1) && (cur_inst.opcode == OP_UB_TO_OFFMEM);
    assign ack_hit     = req_q.cyc && req_q.stb && wb_ack;
    assign wb_req      = req_q;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            req_q <= '0;
            done  <= 1'b0;
        end else begin
            done <= ack_hit;                    // One cycle per ack
            if (start_load || start_store) begin
                req_q.cyc   <= 1'b1;
                req_q.stb   <= 1'b1;
                req_q.we    <= start_store;
                req_q.adr   <= start_store ? cur_inst.addra : cur_inst.addrb;
                req_q.wdata <= start_store ? ub_rdata : '0;
            end else if (ack_hit) begin
                req_q.cyc <= 1'b0;
                req_q.stb <= 1'b0;
            end
        end
    end

    // Read data held for the UB writeback
    always_ff @(posedge clk) begin
        if (ack_hit && !req_q.we) begin
            rdata_q <= wb_rdata;
        end
    end

endmodule

// ==== hdl/sa_ctrl_top.sv ====
`timescale 1ns/100ps

module sa_ctrl_top #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic              clk,
    input  logic              reset_n,
    input  sa_pkg::inst_t     inst,
    input  logic              inst_valid,
    output logic              inst_ready,
    output sa_pkg::wb_req_t   wb_req,
    input  sa_pkg::data_t     wb_rdata,
    input  logic              wb_ack,
    input  sa_pkg::data_t     ub_rdata,
    input  sa_pkg::data_t     acc_rdata,
    output sa_pkg::ub_ctrl_t  ub_ctrl,
    output sa_pkg::acc_ctrl_t acc_ctrl,
    output sa_pkg::mmu_ctrl_t mmu_ctrl,
    output sa_pkg::data_t     ub_wdata,
    output logic              idle
);
    import sa_pkg::*;

    inst_t      head;
    logic       empty;
    logic       pop;
    seq_state_t state;
    inst_t      cur_inst;
    logic       done;
    data_t      rdata_q;

    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) queue0 (
        .clk        (clk),
        .reset_n    (reset_n),
        .push_data  (inst),
        .push_valid (inst_valid),
        .push_ready (inst_ready),
        .pop        (pop),
        .head       (head),
        .empty      (empty)
    );

    cu_sequencer seq0 (
        .clk      (clk),
        .reset_n  (reset_n),
        .head     (head),
        .empty    (empty),
        .pop      (pop),
        .done     (done),
        .state    (state),
        .cur_inst (cur_inst),
        .idle     (idle)
    );

    buffer_port_gen port_gen0 (
        .state     (state),
        .cur_inst  (cur_inst),
        .acc_rdata (acc_rdata),
        .rdata_q   (rdata_q),
        .ub_ctrl   (ub_ctrl),
        .acc_ctrl  (acc_ctrl),
        .mmu_ctrl  (mmu_ctrl),
        .ub_wdata  (ub_wdata)
    );

    offmem_master offmem0 (
        .clk      (clk),
        .reset_n  (reset_n),
        .state    (state),
        .cur_inst (cur_inst),
        .ub_rdata (ub_rdata),
        .wb_req   (wb_req),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack),
        .rdata_q  (rdata_q),
        .done     (done)
    );

endmodule

// ==== hdl/sa_pkg.sv ====
package sa_pkg;

    //////////////////////////////
    // Widths and word types
    //////////////////////////////

    localparam int DATA_W        = 128;
    localparam int OPCODE_W      = 4;
    localparam int OFFMEM_ADDR_W = 32;
    localparam int UB_ADDR_W     = 8;
    localparam int ACC_ADDR_W    = 6;

    typedef logic [DATA_W-1:0]        data_t;
    typedef logic [OFFMEM_ADDR_W-1:0] offmem_addr_t;
    typedef logic [UB_ADDR_W-1:0]     ub_addr_t;
    typedef logic [ACC_ADDR_W-1:0]    acc_addr_t;

    //////////////////////////////
    // Instruction set
    //////////////////////////////

    // Codes 1, 2, 4 and 6 are not decoded and run as a no-op
    typedef enum logic [OPCODE_W-1:0] {
        OP_IDLE            = 4'd0,
        OP_OFFMEM_TO_UB    = 4'd3,
        OP_UB_TO_DATA_FIFO = 4'd5,
        OP_MAT_MUL         = 4'd7,
        OP_MAT_MUL_ACC     = 4'd8,
        OP_ACC_TO_UB       = 4'd9,
        OP_UB_TO_OFFMEM    = 4'd10
    } opcode_t;

    typedef struct packed {
        opcode_t      opcode;
        offmem_addr_t addra;    // Destination
        offmem_addr_t addrb;    // Source
    } inst_t;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_STEP0,
        ST_STEP1,
        ST_BUS,
        ST_WRITEBACK
    } seq_state_t;

    //////////////////////////////
    // Port bundles
    //////////////////////////////

    typedef struct packed {
        logic     rd_en;
        ub_addr_t rd_addr;
        logic     wr_en;
        ub_addr_t wr_addr;
    } ub_ctrl_t;

    typedef struct packed {
        logic      rd_en;
        acc_addr_t rd_addr;
        logic      wr_en;
        acc_addr_t wr_addr;
    } acc_ctrl_t;

    typedef struct packed {
        logic data_fifo_en;
        logic mm_en;
        logic acc_en;
    } mmu_ctrl_t;

    // Wishbone classic master request
    typedef struct packed {
        logic         cyc;
        logic         stb;
        logic         we;
        offmem_addr_t adr;
        data_t        wdata;
    } wb_req_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_sa_ctrl \
    -Mdir obj_dir -o tb_sa_ctrl
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sa_ctrl
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit $status
fi
exit 0
